// File: verilog/contract_pkg.sv
package contract_pkg;

	// Word width, fixed by the RV32 encoding
	localparam int xlen = 32;

	// RV32 major opcodes seen by the monitor
	typedef enum logic [6:0] {
		opc_load = 7'b0000011,
		opc_op_imm = 7'b0010011,
		opc_auipc = 7'b0010111,
		opc_store = 7'b0100011,
		opc_op = 7'b0110011,
		opc_lui = 7'b0110111,
		opc_branch = 7'b1100011,
		opc_jalr = 7'b1100111,
		opc_jal = 7'b1101111
	} opcode_e;

	// Branch conditions in funct3
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [2:0] f3_blt = 3'b100;
	localparam logic [2:0] f3_bge = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// funct7 variants
	localparam logic [6:0] f7_base = 7'b0000000;
	// sub and sra, srai as well
	localparam logic [6:0] f7_alt = 7'b0100000;
	localparam logic [6:0] f7_muldiv = 7'b0000001;

	typedef enum logic [3:0] {
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_branch,
		cls_load,
		cls_store,
		cls_op_imm,
		cls_shift_imm,
		cls_op,
		cls_muldiv,
		cls_illegal
	} insn_class_e;

	// Format views of one instruction word, msb first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		opcode_e opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		opcode_e opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0] rd;
		opcode_e opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		opcode_e opcode;
	} j_fmt_t;

	typedef union packed {
		logic [xlen-1:0] word;
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} insn_u;

	// Operand values as they stand in the retire cycle
	typedef struct packed {
		logic [xlen-1:0] rs1_data;
		logic [xlen-1:0] rs2_data;
		logic [xlen-1:0] rd_wdata;
		logic [xlen-1:0] mem_addr;
	} retire_data_t;

	typedef struct packed {
		insn_class_e insn_class;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [xlen-1:0] imm;
		logic branch_taken;
		logic rs1_zero;
		logic rs2_zero;
		logic rd_zero;
		logic [5:0] rs1_log2;
		logic [5:0] rs2_log2;
		logic [5:0] rd_log2;
		logic mem_aligned;
		logic mem_half_aligned;
	} contract_atoms_t;

endpackage

// File: verilog/insn_classifier.sv
`timescale 1ns/100ps

module insn_classifier import contract_pkg::*; (
	input insn_u insn_i,
	output insn_class_e class_o,
	output logic [2:0] funct3_o,
	output logic [4:0] rd_o,
	output logic [4:0] rs1_o,
	output logic [4:0] rs2_o,
	output logic [xlen-1:0] imm_o
);

	logic [2:0] f3;
	logic [6:0] f7;

	// funct fields sit in the same place in every format that has them
	assign f3 = insn_i.r.funct3;
	assign f7 = insn_i.r.funct7;

	// Class from opcode, funct3 and funct7
	always_comb begin
		class_o = cls_illegal;
		case (insn_i.r.opcode)
			opc_lui: class_o = cls_lui;
			opc_auipc: class_o = cls_auipc;
			opc_jal: class_o = cls_jal;
			opc_jalr: if (f3 == 3'b000) class_o = cls_jalr;
			// funct3 010 and 011 are unused for branches
			opc_branch: if (f3[2:1] != 2'b01) class_o = cls_branch;
			// lb lh lw lbu lhu
			opc_load: if (f3 != 3'b011 && f3 < 3'b110) class_o = cls_load;
			// sb sh sw
			opc_store: if (f3 < 3'b011) class_o = cls_store;
			opc_op_imm: begin
				if (f3 == 3'b001) begin
					if (f7 == f7_base) class_o = cls_shift_imm;
				end else if (f3 == 3'b101) begin
					// srli or srai
					if (f7 == f7_base || f7 == f7_alt) class_o = cls_shift_imm;
				end else begin
					class_o = cls_op_imm;
				end
			end
			opc_op: begin
				if (f7 == f7_base) class_o = cls_op;
				else if (f7 == f7_alt && (f3 == 3'b000 || f3 == 3'b101)) class_o = cls_op;
				else if (f7 == f7_muldiv) class_o = cls_muldiv;
			end
			default: class_o = cls_illegal;
		endcase
	end

	// Fields by the format that the class implies, unused ones stay zero
	always_comb begin
		funct3_o = '0;
		rd_o = '0;
		rs1_o = '0;
		rs2_o = '0;
		imm_o = '0;
		case (class_o)
			cls_lui, cls_auipc: begin
				rd_o = insn_i.u.rd;
				imm_o = {insn_i.u.imm_31_12, 12'b0};
			end
			cls_jal: begin
				rd_o = insn_i.j.rd;
				imm_o = {{11{insn_i.j.imm_20}}, insn_i.j.imm_20, insn_i.j.imm_19_12,
					insn_i.j.imm_11, insn_i.j.imm_10_1, 1'b0};
			end
			cls_jalr, cls_load, cls_op_imm, cls_shift_imm: begin
				funct3_o = insn_i.i.funct3;
				rd_o = insn_i.i.rd;
				rs1_o = insn_i.i.rs1;
				imm_o = {{20{insn_i.i.imm_11_0[11]}}, insn_i.i.imm_11_0};
			end
			cls_branch: begin
				funct3_o = insn_i.b.funct3;
				rs1_o = insn_i.b.rs1;
				rs2_o = insn_i.b.rs2;
				imm_o = {{19{insn_i.b.imm_12}}, insn_i.b.imm_12, insn_i.b.imm_11,
					insn_i.b.imm_10_5, insn_i.b.imm_4_1, 1'b0};
			end
			cls_store: begin
				funct3_o = insn_i.s.funct3;
				rs1_o = insn_i.s.rs1;
				rs2_o = insn_i.s.rs2;
				imm_o = {{20{insn_i.s.imm_11_5[6]}}, insn_i.s.imm_11_5, insn_i.s.imm_4_0};
			end
			// R format has no immediate
			cls_op, cls_muldiv: begin
				funct3_o = insn_i.r.funct3;
				rd_o = insn_i.r.rd;
				rs1_o = insn_i.r.rs1;
				rs2_o = insn_i.r.rs2;
			end
			default: ;
		endcase
	end

endmodule

// File: verilog/branch_resolver.sv
`timescale 1ns/100ps

module branch_resolver import contract_pkg::*; (
	input insn_class_e class_i,
	input logic [2:0] funct3_i,
	input logic [xlen-1:0] rs1_data_i,
	input logic [xlen-1:0] rs2_data_i,
	output logic taken_o
);

	logic eq;
	logic lt;
	logic ltu;

	// Shared comparators
	assign eq = (rs1_data_i == rs2_data_i);
	assign lt = ($signed(rs1_data_i) < $signed(rs2_data_i));
	assign ltu = (rs1_data_i < rs2_data_i);

	always_comb begin
		taken_o = 1'b0;
		case (class_i)
			// Jumps always redirect
			cls_jal, cls_jalr: taken_o = 1'b1;
			cls_branch: begin
				case (funct3_i)
					f3_beq: taken_o = eq;
					f3_bne: taken_o = !eq;
					f3_blt: taken_o = lt;
					f3_bge: taken_o = !lt;
					f3_bltu: taken_o = ltu;
					f3_bgeu: taken_o = !ltu;
					default: taken_o = 1'b0;
				endcase
			end
			default: taken_o = 1'b0;
		endcase
	end

endmodule

// File: verilog/operand_profiler.sv
`timescale 1ns/100ps

module operand_profiler import contract_pkg::*; (
	input retire_data_t operands_i,
	output contract_atoms_t profile_o
);

	// Highest set bit plus one, zero for a zero value
	function automatic logic [5:0] log2_of(input logic [xlen-1:0] value);
		logic [5:0] result;
		result = '0;
		// Last hit wins, so the top bit decides
		for (int i = 0; i < xlen; i++) begin
			if (value[i]) result = 6'(i + 1);
		end
		return result;
	endfunction

	logic [1:0] addr_low;

	assign addr_low = operands_i.mem_addr[1:0];

	always_comb begin
		// Decode fields are filled by the top level
		profile_o = '0;

		profile_o.rs1_zero = (operands_i.rs1_data == '0);
		profile_o.rs2_zero = (operands_i.rs2_data == '0);
		profile_o.rd_zero = (operands_i.rd_wdata == '0);

		profile_o.rs1_log2 = log2_of(operands_i.rs1_data);
		profile_o.rs2_log2 = log2_of(operands_i.rs2_data);
		profile_o.rd_log2 = log2_of(operands_i.rd_wdata);

		// Word access needs both low bits clear
		profile_o.mem_aligned = (addr_low == 2'b00);
		// Only offset 3 makes a halfword cross the word
		profile_o.mem_half_aligned = (addr_low != 2'b11);
	end

endmodule

// File: verilog/core_trace_monitor.sv
`timescale 1ns/100ps

module core_trace_monitor import contract_pkg::*; (
	input logic clock,
	input logic reset,
	input logic stall_i,
	input logic if_kill_i,
	input insn_u insn_i,
	input retire_data_t operands_i,
	output logic atom_valid_o,
	output contract_atoms_t atoms_o
);

	// Execute stage holds a live instruction
	logic exe_valid;
	logic retire;

	insn_class_e insn_class;
	logic [2:0] funct3;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [xlen-1:0] imm;
	logic branch_taken;
	contract_atoms_t profile;
	contract_atoms_t merged;

	// Stall freezes the stage, a fetch kill leaves a bubble behind
	always_ff @(posedge clock) begin
		if (reset) begin
			exe_valid <= 1'b0;
		end else if (!stall_i) begin
			exe_valid <= !if_kill_i;
		end
	end

	// Live instruction leaves execute this cycle
	assign retire = exe_valid && !stall_i;

	insn_classifier u_classifier (
		.insn_i(insn_i),
		.class_o(insn_class),
		.funct3_o(funct3),
		.rd_o(rd),
		.rs1_o(rs1),
		.rs2_o(rs2),
		.imm_o(imm)
	);

	branch_resolver u_resolver (
		.class_i(insn_class),
		.funct3_i(funct3),
		.rs1_data_i(operands_i.rs1_data),
		.rs2_data_i(operands_i.rs2_data),
		.taken_o(branch_taken)
	);

	operand_profiler u_profiler (
		.operands_i(operands_i),
		.profile_o(profile)
	);

	// Decode and branch result on top of the operand profile
	always_comb begin
		merged = profile;
		merged.insn_class = insn_class;
		merged.funct3 = funct3;
		merged.rd = rd;
		merged.rs1 = rs1;
		merged.rs2 = rs2;
		merged.imm = imm;
		merged.branch_taken = branch_taken;
	end

	// One pulse per retirement, a cycle later
	always_ff @(posedge clock) begin
		if (reset) begin
			atom_valid_o <= 1'b0;
		end else begin
			atom_valid_o <= retire;
		end
	end

	// Record holds until the next retirement
	always_ff @(posedge clock) begin
		if (retire) begin
			atoms_o <= merged;
		end
	end

endmodule

// File: tests/core_trace_monitor_asserts.sv
`timescale 1ns/100ps

module core_trace_monitor_asserts (
	input logic clock,
	input logic reset,
	input logic stall_i,
	input logic atom_valid_i
);

	// Strobe cleared by reset
	reset_clears_valid: assert property (@(posedge clock) reset |=> !atom_valid_i)
		else $error("atom_valid_o high after a reset cycle");

	// exe-valid starts low, so the first free cycle has no retirement
	release_no_valid: assert property (@(posedge clock) $fell(reset) |=> !atom_valid_i)
		else $error("atom_valid_o high in the cycle after reset release");

	// A stalled cycle never retires
	stall_blocks_valid: assert property (
		@(posedge clock) disable iff (reset)
		stall_i |=> !atom_valid_i
	) else $error("atom_valid_o followed a stalled cycle");

	// Back to back pulses need two unstalled cycles
	back_to_back_unstalled: assert property (
		@(posedge clock) disable iff (reset)
		(atom_valid_i && $past(atom_valid_i)) |-> (!$past(stall_i) && !$past(stall_i, 2))
	) else $error("Consecutive atom_valid_o pulses around a stalled cycle");

endmodule

// File: tests/core_trace_monitor_tb.sv
`timescale 1ns/100ps

module core_trace_monitor_tb import contract_pkg::*; ();

	logic clock;
	logic reset;
	logic stall_i;
	logic if_kill_i;
	insn_u insn_i;
	retire_data_t operands_i;
	logic atom_valid_o;
	contract_atoms_t atoms_o;

	// Model state and bookkeeping
	logic exe_valid_model;
	contract_atoms_t expected_q[$];
	string name_q[$];
	contract_atoms_t last_record;
	logic have_record;
	int value_errors;
	int timing_errors;
	int other_errors;
	int retirements;
	int pulses;

	core_trace_monitor dut0 (
		.clock(clock),
		.reset(reset),
		.stall_i(stall_i),
		.if_kill_i(if_kill_i),
		.insn_i(insn_i),
		.operands_i(operands_i),
		.atom_valid_o(atom_valid_o),
		.atoms_o(atoms_o)
	);

	bind core_trace_monitor core_trace_monitor_asserts u_asserts (
		.clock(clock),
		.reset(reset),
		.stall_i(stall_i),
		.atom_valid_i(atom_valid_o)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Highest set bit plus one by shifting the value out
	function automatic logic [5:0] log2_ref(input logic [31:0] value);
		int n;
		logic [31:0] rest;
		n = 0;
		rest = value;
		while (rest != 0) begin
			rest = rest >> 1;
			n++;
		end
		return 6'(n);
	endfunction

	function automatic logic taken_ref(input insn_class_e cls, input logic [2:0] f3,
		input logic [31:0] a, input logic [31:0] b);
		if (cls == cls_jal || cls == cls_jalr) return 1'b1;
		if (cls != cls_branch) return 1'b0;
		case (f3)
			f3_beq: return a == b;
			f3_bne: return a != b;
			f3_blt: return $signed(a) < $signed(b);
			f3_bge: return $signed(a) >= $signed(b);
			f3_bltu: return a < b;
			f3_bgeu: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [2:0] branch_f3(input int k);
		case (k % 6)
			0: return f3_beq;
			1: return f3_bne;
			2: return f3_blt;
			3: return f3_bge;
			4: return f3_bltu;
			default: return f3_bgeu;
		endcase
	endfunction

	// Zero, one bit, all ones, sign boundaries or random
	function automatic logic [31:0] pick_operand();
		case ($urandom % 8)
			0: return 32'h0;
			1: return 32'h1 << ($urandom % 32);
			2: return 32'hffffffff;
			3: return 32'h80000000;
			4: return 32'h7fffffff;
			default: return $urandom;
		endcase
	endfunction

	// Encodes one instruction of a class along with its expected decode
	task automatic build_insn(input int sel, input int sub, output logic [31:0] word,
		output contract_atoms_t expected);
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [31:0] imm;
		logic [2:0] f3;
		rd = 5'($urandom);
		rs1 = 5'($urandom);
		rs2 = 5'($urandom);
		imm = $urandom;
		f3 = 3'($urandom);
		expected = '0;
		case (sel)
			0, 1: begin
				imm = {imm[31:12], 12'b0};
				word = {imm[31:12], rd, (sel == 0) ? opc_lui : opc_auipc};
				expected.insn_class = (sel == 0) ? cls_lui : cls_auipc;
			end
			2: begin
				imm = {{11{imm[20]}}, imm[20:1], 1'b0};
				word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
				expected.insn_class = cls_jal;
			end
			// I format jalr lw and addi
			3, 5, 7: begin
				imm = {{20{imm[11]}}, imm[11:0]};
				f3 = (sel == 5) ? 3'b010 : 3'b000;
				word = {imm[11:0], rs1, f3, rd, (sel == 3) ? opc_jalr :
					(sel == 5) ? opc_load : opc_op_imm};
				expected.insn_class = (sel == 3) ? cls_jalr : (sel == 5) ? cls_load : cls_op_imm;
			end
			4: begin
				f3 = branch_f3(sub);
				imm = {{19{imm[12]}}, imm[12:1], 1'b0};
				word = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
				expected.insn_class = cls_branch;
			end
			6: begin
				imm = {{20{imm[11]}}, imm[11:0]};
				f3 = 3'b010;
				word = {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
				expected.insn_class = cls_store;
			end
			// srai with shamt in the rs2 slot
			8: begin
				f3 = 3'b101;
				imm = {20'b0, f7_alt, rs2};
				word = {f7_alt, rs2, rs1, f3, rd, opc_op_imm};
				expected.insn_class = cls_shift_imm;
			end
			// sub then the mul family
			9, 10: begin
				f3 = (sel == 9) ? 3'b000 : f3;
				word = {(sel == 9) ? f7_alt : f7_muldiv, rs2, rs1, f3, rd, opc_op};
				expected.insn_class = (sel == 9) ? cls_op : cls_muldiv;
			end
			default: begin
				word = {7'b0100001, rs2, rs1, 3'b000, rd, opc_op};
				expected.insn_class = cls_illegal;
			end
		endcase
		// Fields that the format carries
		if (expected.insn_class != cls_illegal) begin
			expected.imm = (sel == 9 || sel == 10) ? 32'h0 : imm;
			expected.rd = (sel == 4 || sel == 6) ? 5'h0 : rd;
			expected.rs1 = (sel < 3) ? 5'h0 : rs1;
			expected.rs2 = (sel == 4 || sel == 6 || sel == 9 || sel == 10) ? rs2 : 5'h0;
			expected.funct3 = (sel < 3) ? 3'h0 : f3;
		end
	endtask

	// Samples outputs of the last rising edge
	task automatic check_outputs(input logic pulse_expected, input string test);
		contract_atoms_t expected;
		string name;
		assert (atom_valid_o === pulse_expected) else begin
			$display("CHECK FAILED %s atom_valid_o expected %0b actual %0b", test,
				pulse_expected, atom_valid_o);
			timing_errors++;
		end
		if (atom_valid_o === 1'b1) begin
			pulses++;
			if (expected_q.size() == 0) begin
				$display("ERROR atom_valid_o pulsed with no retirement outstanding");
				other_errors++;
			end else begin
				expected = expected_q.pop_front();
				name = name_q.pop_front();
				assert (atoms_o === expected) else begin
					$display("CHECK FAILED %s expected %h actual %h", name, expected, atoms_o);
					value_errors++;
				end
				last_record = expected;
				have_record = 1'b1;
			end
		end else if (have_record) begin
			// Record stays put between pulses
			assert (atoms_o === last_record) else begin
				$display("CHECK FAILED %s atoms_o hold expected %h actual %h", test,
					last_record, atoms_o);
				value_errors++;
			end
		end
	endtask

	// One clock of stimulus, model update and check
	task automatic run_cycle(input logic stall, input logic kill, input int sel, input int sub,
		input string test);
		logic [31:0] word;
		contract_atoms_t expected;
		retire_data_t ops;
		logic retire;
		build_insn(sel, sub, word, expected);
		ops.rs1_data = pick_operand();
		// Equal operands now and then for beq and bge
		ops.rs2_data = ($urandom % 4 == 0) ? ops.rs1_data : pick_operand();
		ops.rd_wdata = pick_operand();
		ops.mem_addr = $urandom;
		expected.branch_taken = taken_ref(expected.insn_class, expected.funct3,
			ops.rs1_data, ops.rs2_data);
		expected.rs1_zero = (ops.rs1_data == 32'h0);
		expected.rs2_zero = (ops.rs2_data == 32'h0);
		expected.rd_zero = (ops.rd_wdata == 32'h0);
		expected.rs1_log2 = log2_ref(ops.rs1_data);
		expected.rs2_log2 = log2_ref(ops.rs2_data);
		expected.rd_log2 = log2_ref(ops.rd_wdata);
		expected.mem_aligned = (ops.mem_addr[1:0] == 2'b00);
		expected.mem_half_aligned = !(ops.mem_addr[1] && ops.mem_addr[0]);

		stall_i = stall;
		if_kill_i = kill;
		insn_i.word = word;
		operands_i = ops;

		retire = exe_valid_model && !stall;
		if (retire) begin
			expected_q.push_back(expected);
			name_q.push_back(test);
			retirements++;
		end
		if (!stall) exe_valid_model = !kill;
		@(negedge clock);
		check_outputs(retire, test);
	endtask

	// Kill cycles until every queued record has come out
	task automatic drain_records();
		int waited;
		waited = 0;
		while (expected_q.size() != 0 && waited < 20) begin
			run_cycle(1'b0, 1'b1, 0, 0, "drain");
			waited++;
		end
		if (expected_q.size() != 0) begin
			$display("ERROR timed out waiting for atom_valid_o to deliver queued records");
			other_errors++;
		end
	endtask

	initial begin
		void'($urandom(32'heba22b11));
		value_errors = 0;
		timing_errors = 0;
		other_errors = 0;
		retirements = 0;
		pulses = 0;
		exe_valid_model = 1'b0;
		have_record = 1'b0;
		last_record = '0;
		reset = 1'b1;
		stall_i = 1'b0;
		if_kill_i = 1'b0;
		insn_i = '0;
		operands_i = '0;

		// No pulse while reset is held
		repeat (4) begin
			@(negedge clock);
			check_outputs(1'b0, "reset");
		end
		reset = 1'b0;

		// First cycle out of reset never retires
		run_cycle(1'b0, 1'b0, 0, 0, "reset_release");

		for (int k = 0; k < 12; k++) begin
			repeat (3) run_cycle(1'b0, 1'b0, k, $urandom, "classify");
		end

		for (int c = 0; c < 6; c++) begin
			repeat (12) run_cycle(1'b0, 1'b0, 4, c, "branch");
		end
		repeat (5) run_cycle(1'b0, 1'b0, 2, 0, "jump_jal");
		repeat (5) run_cycle(1'b0, 1'b0, 3, 0, "jump_jalr");

		repeat (40) run_cycle(1'b0, 1'b0, $urandom % 12, $urandom, "profile");

		// Random stall windows and kill cycles
		repeat (300) begin
			run_cycle($urandom % 4 == 0, $urandom % 5 == 0, $urandom % 12, $urandom,
				"retire_timing");
		end

		drain_records();

		assert (pulses == retirements) else begin
			$display("CHECK FAILED record_count expected %0d actual %0d", retirements, pulses);
			value_errors++;
		end

		$display("Errors: %0d value, %0d timing, %0d other over %0d records",
			value_errors, timing_errors, other_errors, pulses);
		if (value_errors + timing_errors + other_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: list.f
verilog/contract_pkg.sv
verilog/insn_classifier.sv
verilog/branch_resolver.sv
verilog/operand_profiler.sv
verilog/core_trace_monitor.sv
tests/core_trace_monitor_asserts.sv
tests/core_trace_monitor_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS := --binary --timing --assert -j 0
TOP := core_trace_monitor_tb
FILELIST := list.f
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
